/* cpu_pkg.sv */
package cpu_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_AW    = 5;
    localparam int REG_COUNT = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // Function codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef enum logic [3:0] {
        NOP, OR, AND, XOR, NOR, SLL, SRL, SRA, ADD, SUB, SLT, SLTU
    } alu_op_e;

    typedef struct packed {
        logic [5:0] op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    // The opcode decides which view applies
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_u;

endpackage

/* issue_if.sv */
`timescale 1ns/1ps

interface issue_if;
    import cpu_pkg::*;

    logic      valid;
    alu_op_e   op;
    word_t     opnd1;
    word_t     opnd2;
    reg_addr_t wd;
    logic      we;

    // Decode drives everything combinationally
    modport src (output valid, op, opnd1, opnd2, wd, we);

    // Execute samples into its issue register
    modport dst (input valid, op, opnd1, opnd2, wd, we);

endinterface

/* inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  cpu_pkg::word_t     inst_i,
    output cpu_pkg::alu_op_e   op_o,
    output logic               re1_o,
    output logic               re2_o,
    output cpu_pkg::reg_addr_t raddr1_o,
    output cpu_pkg::reg_addr_t raddr2_o,
    output cpu_pkg::word_t     imm_o,
    output cpu_pkg::reg_addr_t wd_o,
    output logic               we_o
);
    import cpu_pkg::*;

    inst_u ins;
    logic  known;
    word_t imm_zext;
    word_t imm_sext;
    word_t imm_shamt;

    assign ins       = inst_i;
    assign imm_zext  = {16'h0, ins.i.imm};
    assign imm_sext  = {{16{ins.i.imm[15]}}, ins.i.imm};
    assign imm_shamt = {27'h0, ins.r.shamt};

    assign raddr1_o = ins.r.rs;
    assign raddr2_o = ins.r.rt;

    always_comb begin
        op_o  = NOP;
        re1_o = 1'b0;
        re2_o = 1'b0;
        imm_o = '0;
        known = 1'b1;
        if (ins.r.op == OP_SPECIAL) begin
            wd_o  = ins.r.rd;
            re1_o = 1'b1;
            re2_o = 1'b1;
            case (ins.r.funct)
                FN_OR:   op_o = OR;
                FN_AND:  op_o = AND;
                FN_XOR:  op_o = XOR;
                FN_NOR:  op_o = NOR;
                FN_SLLV: op_o = SLL; // Shift amount comes from rs
                FN_SRLV: op_o = SRL;
                FN_SRAV: op_o = SRA;
                FN_ADD,
                FN_ADDU: op_o = ADD; // No overflow trap in this core
                FN_SUB,
                FN_SUBU: op_o = SUB;
                FN_SLT:  op_o = SLT;
                FN_SLTU: op_o = SLTU;
                FN_SLL, FN_SRL, FN_SRA: begin
                    // Constant shifts take shamt in place of rs
                    op_o  = (ins.r.funct == FN_SLL) ? SLL :
                            (ins.r.funct == FN_SRL) ? SRL : SRA;
                    re1_o = 1'b0;
                    imm_o = imm_shamt;
                end
                default: begin
                    re1_o = 1'b0;
                    re2_o = 1'b0;
                    known = 1'b0;
                end
            endcase
        end else begin
            wd_o  = ins.i.rt;
            re1_o = 1'b1;
            case (ins.i.op)
                OP_ORI:  op_o = OR;
                OP_ANDI: op_o = AND;
                OP_XORI: op_o = XOR;
                OP_ADDI,
                OP_ADDIU: op_o = ADD;
                OP_SLTI:  op_o = SLT;
                OP_SLTIU: op_o = SLTU;
                OP_LUI: begin
                    op_o  = OR;    // Both operands are the immediate
                    re1_o = 1'b0;
                end
                default: begin
                    re1_o = 1'b0;
                    known = 1'b0;
                end
            endcase
            case (ins.i.op)
                OP_ORI, OP_ANDI, OP_XORI: imm_o = imm_zext;
                OP_LUI:                   imm_o = {ins.i.imm, 16'h0};
                default:                  imm_o = imm_sext;
            endcase
        end
        // r0 is never written
        we_o = known && (wd_o != '0);
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  cpu_pkg::word_t     inst_i,
    input  logic               inst_valid_i,
    output cpu_pkg::reg_addr_t rf_raddr1_o,
    output cpu_pkg::reg_addr_t rf_raddr2_o,
    input  cpu_pkg::word_t     rf_rdata1_i,
    input  cpu_pkg::word_t     rf_rdata2_i,
    input  logic               ex_we_i,
    input  cpu_pkg::reg_addr_t ex_wd_i,
    input  cpu_pkg::word_t     ex_wdata_i,
    input  logic               mem_we_i,
    input  cpu_pkg::reg_addr_t mem_wd_i,
    input  cpu_pkg::word_t     mem_wdata_i,
    issue_if.src               iss
);
    import cpu_pkg::*;

    logic  re1;
    logic  re2;
    word_t imm;

    // Youngest producer wins, then the one in the result register
    function automatic word_t pick_opnd(input logic re, input reg_addr_t addr,
                                        input word_t rdata);
        if (re && ex_we_i && addr == ex_wd_i)
            return ex_wdata_i;
        else if (re && mem_we_i && addr == mem_wd_i)
            return mem_wdata_i;
        else if (re)
            return rdata;
        else
            return imm;
    endfunction

    inst_decoder u_dec (
        .inst_i   (inst_i),
        .op_o     (iss.op),
        .re1_o    (re1),
        .re2_o    (re2),
        .raddr1_o (rf_raddr1_o),
        .raddr2_o (rf_raddr2_o),
        .imm_o    (imm),
        .wd_o     (iss.wd),
        .we_o     (iss.we)
    );

    assign iss.valid = inst_valid_i;

    always_comb begin
        iss.opnd1 = pick_opnd(re1, rf_raddr1_o, rf_rdata1_i);
        iss.opnd2 = pick_opnd(re2, rf_raddr2_o, rf_rdata2_i);
    end

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_e op_i,
    input  cpu_pkg::word_t   a_i,
    input  cpu_pkg::word_t   b_i,
    output cpu_pkg::word_t   result_o
);
    import cpu_pkg::*;

    logic [4:0] sh;
    logic       lt_signed;
    logic       lt_unsigned;

    assign sh          = a_i[4:0]; // Shifts move b_i by a_i
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            OR:      result_o = a_i | b_i;
            AND:     result_o = a_i & b_i;
            XOR:     result_o = a_i ^ b_i;
            NOR:     result_o = ~(a_i | b_i);
            SLL:     result_o = b_i << sh;
            SRL:     result_o = b_i >> sh;
            SRA:     result_o = word_t'($signed(b_i) >>> sh);
            ADD:     result_o = a_i + b_i; // Wraps
            SUB:     result_o = a_i - b_i;
            SLT:     result_o = word_t'(lt_signed);
            SLTU:    result_o = word_t'(lt_unsigned);
            default: result_o = '0;
        endcase
    end

endmodule

/* exec_pipe.sv */
`timescale 1ns/1ps

module exec_pipe (
    input  logic               clk,
    input  logic               rst_i,
    issue_if.dst               iss,
    input  logic               wb_ready_i,
    output logic               inst_ready_o,
    output logic               ex_we_o,
    output cpu_pkg::reg_addr_t ex_wd_o,
    output cpu_pkg::word_t     ex_wdata_o,
    output logic               mem_we_o,
    output cpu_pkg::reg_addr_t mem_wd_o,
    output cpu_pkg::word_t     mem_wdata_o,
    output logic               wb_valid_o,
    output logic               wb_we_o,
    output cpu_pkg::reg_addr_t wb_addr_o,
    output cpu_pkg::word_t     wb_data_o,
    output logic               rf_we_o
);
    import cpu_pkg::*;

    logic      iss_valid;
    logic      iss_we;
    alu_op_e   iss_op;
    word_t     iss_a;
    word_t     iss_b;
    reg_addr_t iss_wd;
    word_t     alu_result;
    logic      res_valid;
    logic      res_we;
    reg_addr_t res_wd;
    word_t     res_data;
    logic      stall;

    // A held beat that nobody takes freezes the whole pipe
    assign stall        = res_valid && !wb_ready_i;
    assign inst_ready_o = !stall;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            iss_valid <= 1'b0;
            iss_we    <= 1'b0;
            res_valid <= 1'b0;
            res_we    <= 1'b0;
        end else if (!stall) begin
            iss_valid <= iss.valid;
            iss_we    <= iss.we;
            res_valid <= iss_valid;
            res_we    <= iss_we;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            iss_op   <= iss.op;
            iss_a    <= iss.opnd1;
            iss_b    <= iss.opnd2;
            iss_wd   <= iss.wd;
            res_wd   <= iss_wd;
            res_data <= alu_result;
        end
    end

    alu u_alu (
        .op_i     (iss_op),
        .a_i      (iss_a),
        .b_i      (iss_b),
        .result_o (alu_result)
    );

    assign ex_we_o     = iss_valid && iss_we;
    assign ex_wd_o     = iss_wd;
    assign ex_wdata_o  = alu_result;
    assign mem_we_o    = res_valid && res_we;
    assign mem_wd_o    = res_wd;
    assign mem_wdata_o = res_data;

    assign wb_valid_o = res_valid;
    assign wb_we_o    = res_we;
    assign wb_addr_o  = res_wd;
    assign wb_data_o  = res_data;
    assign rf_we_o    = res_valid && wb_ready_i && res_we; // Write lands on the transfer edge

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst_i,
    input  cpu_pkg::reg_addr_t raddr1_i,
    input  cpu_pkg::reg_addr_t raddr2_i,
    output cpu_pkg::word_t     rdata1_o,
    output cpu_pkg::word_t     rdata2_o,
    input  logic               we_i,
    input  cpu_pkg::reg_addr_t waddr_i,
    input  cpu_pkg::word_t     wdata_i
);
    import cpu_pkg::*;

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Reads see the old value during a write, decode forwards around it
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* mini_core.sv */
`timescale 1ns/1ps

module mini_core (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               inst_valid_i,
    input  cpu_pkg::word_t     inst_i,
    output logic               inst_ready_o,
    output logic               wb_valid_o,
    output logic               wb_we_o,
    output cpu_pkg::reg_addr_t wb_addr_o,
    output cpu_pkg::word_t     wb_data_o,
    input  logic               wb_ready_i
);
    import cpu_pkg::*;

    issue_if iss ();

    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    logic      rf_we;
    logic      ex_we;
    reg_addr_t ex_wd;
    word_t     ex_wdata;
    logic      mem_we;
    reg_addr_t mem_wd;
    word_t     mem_wdata;

    decode_stage u_decode (
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .rf_raddr1_o  (rf_raddr1),
        .rf_raddr2_o  (rf_raddr2),
        .rf_rdata1_i  (rf_rdata1),
        .rf_rdata2_i  (rf_rdata2),
        .ex_we_i      (ex_we),
        .ex_wd_i      (ex_wd),
        .ex_wdata_i   (ex_wdata),
        .mem_we_i     (mem_we),
        .mem_wd_i     (mem_wd),
        .mem_wdata_i  (mem_wdata),
        .iss          (iss.src)
    );

    exec_pipe u_exec (
        .clk          (clk),
        .rst_i        (rst_i),
        .iss          (iss.dst),
        .wb_ready_i   (wb_ready_i),
        .inst_ready_o (inst_ready_o),
        .ex_we_o      (ex_we),
        .ex_wd_o      (ex_wd),
        .ex_wdata_o   (ex_wdata),
        .mem_we_o     (mem_we),
        .mem_wd_o     (mem_wd),
        .mem_wdata_o  (mem_wdata),
        .wb_valid_o   (wb_valid_o),
        .wb_we_o      (wb_we_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .rf_we_o      (rf_we)
    );

    // The write port takes the beat that leaves on the write-back stream
    reg_file u_rf (
        .clk      (clk),
        .rst_i    (rst_i),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .we_i     (rf_we),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o)
    );

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // Reset covers two rising edges and drops on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

/* tb_top.sv */
`timescale 1ns/1ps

module tb_top;
    import cpu_pkg::*;

    localparam int LIMIT = 200;

    logic      clk;
    logic      rst_i;
    logic      inst_valid_i;
    word_t     inst_i;
    logic      inst_ready_o;
    logic      wb_valid_o;
    logic      wb_we_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;
    logic      wb_ready_i;

    word_t       model_regs [REG_COUNT];
    logic [37:0] exp_q [$];
    int          err_count = 0;
    int          test_errs;
    int          tests_ok = 0;
    int          tests_bad = 0;
    string       cur_test = "reset";
    logic        rand_ready = 1'b0;
    logic        timed_out = 1'b0;

    tb_clock u_clk (.clk_o(clk), .rst_o(rst_i));

    mini_core dut0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_ready_o (inst_ready_o),
        .wb_valid_o   (wb_valid_o),
        .wb_we_o      (wb_we_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .wb_ready_i   (wb_ready_i)
    );

    // Expected beat {we, addr, data} straight from the instruction set rules
    function automatic logic [37:0] model_step(input word_t w);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sh;
        reg_addr_t   addr;
        word_t       a;
        word_t       b;
        word_t       sx;
        word_t       zx;
        word_t       d;
        logic        known;
        logic        we;
        op    = w[31:26];
        fn    = w[5:0];
        sh    = w[10:6];
        a     = model_regs[w[25:21]];
        b     = model_regs[w[20:16]];
        sx    = {{16{w[15]}}, w[15:0]};
        zx    = {16'h0, w[15:0]};
        d     = '0;
        known = 1'b1;
        addr  = (op == OP_SPECIAL) ? w[15:11] : w[20:16];
        if (op == OP_SPECIAL) begin
            case (fn)
                FN_OR:           d = a | b;
                FN_AND:          d = a & b;
                FN_XOR:          d = a ^ b;
                FN_NOR:          d = ~(a | b);
                FN_SLL:          d = b << sh;
                FN_SRL:          d = b >> sh;
                FN_SRA:          d = $signed(b) >>> sh;
                FN_SLLV:         d = b << a[4:0];
                FN_SRLV:         d = b >> a[4:0];
                FN_SRAV:         d = $signed(b) >>> a[4:0];
                FN_ADD, FN_ADDU: d = a + b;
                FN_SUB, FN_SUBU: d = a - b;
                FN_SLT:          d = {31'h0, $signed(a) < $signed(b)};
                FN_SLTU:         d = {31'h0, a < b};
                default:         known = 1'b0;
            endcase
        end else begin
            case (op)
                OP_ORI:            d = a | zx;
                OP_ANDI:           d = a & zx;
                OP_XORI:           d = a ^ zx;
                OP_LUI:            d = {w[15:0], 16'h0};
                OP_ADDI, OP_ADDIU: d = a + sx;
                OP_SLTI:           d = {31'h0, $signed(a) < $signed(sx)};
                OP_SLTIU:          d = {31'h0, a < sx};
                default:           known = 1'b0;
            endcase
        end
        we = known && (addr != 5'd0);
        if (we)
            model_regs[addr] = d;
        return {we, addr, d};
    endfunction

    always @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < REG_COUNT; i++)
                model_regs[i] = '0;
        end else begin
            if (wb_valid_o && wb_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("Error in %s: write-back beat with no accepted instruction",
                             cur_test);
                    err_count++;
                end else begin
                    logic [37:0] exp_beat;
                    exp_beat = exp_q.pop_front();
                    assert (wb_we_o == exp_beat[37] && wb_addr_o == exp_beat[36:32] &&
                            (!exp_beat[37] || wb_data_o == exp_beat[31:0]))
                    else begin
                        $display("Error in %s: expected %h actual %h", cur_test, exp_beat,
                                 {wb_we_o, wb_addr_o, wb_data_o});
                        err_count++;
                    end
                end
            end
            if (inst_valid_i && inst_ready_o)
                exp_q.push_back(model_step(inst_i));
        end
    end

    a_reset_clear: assert property (@(posedge clk) $past(rst_i) |-> !wb_valid_o)
    else begin
        $display("Error in %s: wb_valid_o high right after reset", cur_test);
        err_count++;
    end

    // Accepted, then one advancing edge, then the beat is out
    a_latency: assert property (@(posedge clk) disable iff (rst_i)
        ($past(inst_valid_i && inst_ready_o, 2) && $past(inst_ready_o, 1)) |-> wb_valid_o)
    else begin
        $display("Error in %s: beat missing two cycles after acceptance", cur_test);
        err_count++;
    end

    a_stall_stable: assert property (@(posedge clk) disable iff (rst_i)
        $past(wb_valid_o && !wb_ready_i) |->
            (wb_valid_o && $stable(wb_we_o) && $stable(wb_addr_o) && $stable(wb_data_o)))
    else begin
        $display("Error in %s: held beat changed while stalled", cur_test);
        err_count++;
    end

    always @(negedge clk) begin
        if (rand_ready)
            wb_ready_i = ($urandom_range(0, 2) != 0);
    end

    task automatic give_up(input string what);
        $display("Timeout in %s while %s", cur_test, what);
        timed_out = 1'b1;
    endtask

    initial begin
        @(posedge timed_out);
        $display("Simulation failed");
        $finish;
    end

    // Called on a falling edge and returns on the falling edge after acceptance
    task automatic send_inst(input word_t w);
        int   waited;
        logic acc;
        waited       = 0;
        inst_valid_i = 1'b1;
        inst_i       = w;
        forever begin
            #1;
            acc = inst_ready_o;
            @(negedge clk);
            if (acc)
                break;
            waited++;
            if (waited > LIMIT)
                give_up("waiting for inst_ready_o");
        end
        inst_valid_i = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > LIMIT)
                give_up("waiting for write-back beats");
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = err_count;
    endtask

    task automatic end_test();
        drain();
        if (err_count == test_errs) begin
            tests_ok++;
            $display("Test %s: ok", cur_test);
        end else begin
            tests_bad++;
            $display("Test %s: FAILED with %0d errors", cur_test, err_count - test_errs);
        end
    endtask

    function automatic word_t r_inst(input int rs, input int rt, input int rd, input int sh,
                                     input logic [5:0] fn);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic word_t i_inst(input logic [5:0] op, input int rs, input int rt,
                                     input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    logic [5:0] fn_list [16] = '{FN_OR, FN_AND, FN_XOR, FN_NOR, FN_SLL, FN_SRL, FN_SRA,
        FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
    logic [5:0] op_list [8] = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU,
        OP_SLTI, OP_SLTIU};

    initial begin
        int    pick;
        int    waited;
        word_t rnd;
        void'($urandom(32'hafbd4baa));
        inst_valid_i = 1'b0;
        inst_i       = '0;
        wb_ready_i   = 1'b1;
        waited       = 0;
        @(negedge clk);
        while (rst_i) begin
            @(negedge clk);
            waited++;
            if (waited > LIMIT)
                give_up("waiting for reset to end");
        end

        start_test("reset_latency");
        assert (!wb_valid_o && inst_ready_o)
        else begin
            $display("Error in %s: expected idle outputs after reset", cur_test);
            err_count++;
        end
        send_inst(i_inst(OP_ORI, 0, 1, 16'h1234));
        end_test();

        start_test("immediates");
        send_inst(i_inst(OP_ORI, 0, 2, 16'hf0f0));
        send_inst(i_inst(OP_ANDI, 2, 3, 16'h3c3c));
        send_inst(i_inst(OP_XORI, 2, 4, 16'hffff));
        send_inst(i_inst(OP_LUI, 0, 5, 16'h8765));
        send_inst(i_inst(OP_ADDI, 2, 6, 16'hff00));
        send_inst(i_inst(OP_ADDIU, 0, 7, 16'h8000));
        send_inst(i_inst(OP_SLTI, 7, 8, 16'hfff0));
        send_inst(i_inst(OP_SLTIU, 2, 9, 16'hfff0));
        end_test();

        start_test("r_type");
        for (int i = 0; i < 16; i++)
            send_inst(r_inst(5 + i % 3, 2 + i % 5, 10 + i, i + 3, fn_list[i]));
        end_test();

        start_test("forwarding");
        send_inst(i_inst(OP_ADDIU, 0, 1, 16'h0005));
        send_inst(r_inst(1, 1, 2, 0, FN_ADDU));
        send_inst(r_inst(1, 2, 3, 0, FN_SUBU));
        send_inst(r_inst(3, 2, 1, 0, FN_XOR));
        send_inst(i_inst(OP_ADDI, 1, 1, 16'hfffe));
        send_inst(r_inst(1, 3, 4, 0, FN_SLLV));
        end_test();

        start_test("random_flow");
        rand_ready = 1'b1;
        for (int i = 0; i < 60; i++) begin
            rnd  = $urandom();
            pick = $urandom_range(0, 23);
            if (pick < 16)
                send_inst(r_inst($urandom_range(0, 7), $urandom_range(0, 7),
                                 $urandom_range(1, 7), rnd[20:16], fn_list[pick]));
            else
                send_inst(i_inst(op_list[pick-16], $urandom_range(0, 7),
                                 $urandom_range(1, 7), rnd[15:0]));
            repeat ($urandom_range(0, 2)) @(negedge clk);
        end
        @(negedge clk);
        rand_ready = 1'b0;
        wb_ready_i = 1'b1;
        end_test();

        start_test("unknown_and_r0");
        send_inst(i_inst(6'b111111, 1, 2, 16'h0001));
        send_inst(r_inst(1, 2, 3, 0, 6'b111011));
        send_inst(i_inst(OP_ORI, 0, 0, 16'h5555));
        send_inst(r_inst(1, 2, 0, 0, FN_ADDU));
        send_inst(r_inst(0, 0, 5, 0, FN_OR));
        end_test();

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_ok, tests_bad, err_count);
        if (err_count == 0 && tests_bad == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* list.f */
cpu_pkg.sv
issue_if.sv
inst_decoder.sv
decode_stage.sv
alu.sv
exec_pipe.sv
reg_file.sv
mini_core.sv
tb_clock.sv
tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f list.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator returned status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
